// ==== build.f ====
+incdir+src
src/periph_pkg.sv
src/apb_periph_decoder.sv
src/irq_gateway.sv
src/plic_core.sv
src/apb_timer.sv
src/periph_top.sv
testbench/tb_clock_gen.sv
testbench/periph_properties.sv
testbench/tb_periph.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the peripheral testbench with Verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_periph \
    && ./obj_dir/Vtb_periph 2>&1 | tee sim.log \
    && ! grep -q "ERRORS FOUND" sim.log \
    && grep -q "NO ERRORS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== testbench/tb_periph.sv ====
/*
 * Peripheral subsystem testbench
 * Drives APB transfers and interrupt inputs, predicts claims with a
 * reference model and checks read data, claim IDs and eip_o
 */
`timescale 1ns/1ps
`default_nettype none

`include "periph_settings.svh"

module tb_periph;
    import periph_pkg::*;

    localparam int TIMEOUT = 200;
    localparam int PW      = `PERIPH_PRIO_W;

    logic     clk;
    logic     rst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    ext_irq_t irq;
    tgt_vec_t eip;

    // Model of the interrupt controller state
    logic [`PERIPH_NUM_SRC*PW-1:0] prio_m;
    src_vec_t                      en_m  [`PERIPH_NUM_TGT];
    prio_t                         thr_m [`PERIPH_NUM_TGT];
    src_vec_t                      pend_m;

    data_t   exp_data_q [$];
    data_t   got_data_q [$];
    string   data_tag_q [$];
    src_id_t exp_id_q   [$];
    src_id_t got_id_q   [$];
    string   id_tag_q   [$];

    int data_errors;
    int id_errors;
    int eip_errors;
    int timeouts;

    tb_clock_gen u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    periph_top DUT (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp),
        .irq_i     (irq),
        .eip_o     (eip)
    );

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic src_id_t ref_claim(input src_vec_t pend, input src_vec_t en,
                                          input logic [`PERIPH_NUM_SRC*PW-1:0] prios,
                                          input prio_t thr);
        prio_t   top;
        src_id_t id;
        top = '0;
        id  = '0;
        // Best level among candidates above threshold
        for (int i = 1; i < `PERIPH_NUM_SRC; i++) begin
            if (pend[i] && en[i] && prios[i*PW +: PW] > thr && prios[i*PW +: PW] > top) begin
                top = prios[i*PW +: PW];
            end
        end
        // Lowest ID at that level
        for (int i = `PERIPH_NUM_SRC - 1; i >= 1; i--) begin
            if (top != '0 && pend[i] && en[i] && prios[i*PW +: PW] == top) begin
                id = src_id_t'(i);
            end
        end
        return id;
    endfunction

    function automatic tgt_vec_t ref_eip();
        tgt_vec_t e;
        for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
            e[t] = (ref_claim(pend_m, en_m[t], prio_m, thr_m[t]) != '0);
        end
        return e;
    endfunction

    function automatic addr_t plic_addr(input int off);
        return {`PERIPH_REGION_PLIC, 12'(off)};
    endfunction

    function automatic addr_t tmr_addr(input int off);
        return {`PERIPH_REGION_TIMER, 12'(off)};
    endfunction

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_data(input data_t got, input data_t exp, input string tag);
        if (got !== exp) begin
            data_errors++;
            $display("FAIL %0t: %s expected %h got %h", $time, tag, exp, got);
        end
    endtask

    task automatic check_id(input src_id_t got, input src_id_t exp, input string tag);
        if (got !== exp) begin
            id_errors++;
            $display("FAIL %0t: %s expected ID %0d got %0d", $time, tag, exp, got);
        end
    endtask

    task automatic check_eip(input tgt_vec_t got, input tgt_vec_t exp, input string tag);
        if (got !== exp) begin
            eip_errors++;
            $display("FAIL %0t: %s expected eip %b got %b", $time, tag, exp, got);
        end
    endtask

    // Read results are checked one edge after they are queued
    always @(posedge clk) begin
        while (got_data_q.size() > 0) begin
            check_data(got_data_q.pop_front(), exp_data_q.pop_front(), data_tag_q.pop_front());
        end
        while (got_id_q.size() > 0) begin
            check_id(got_id_q.pop_front(), exp_id_q.pop_front(), id_tag_q.pop_front());
        end
    end

    // ------------------------------------------------------------
    // APB master
    // ------------------------------------------------------------
    task automatic run_transfer(input logic write, input addr_t addr, input data_t wdata,
                                output data_t rdata, output logic err);
        int cnt;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);
        cnt = 0;
        while (!apb_rsp.pready && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!apb_rsp.pready) begin
            timeouts++;
            $display("APB transfer to address %h never got pready", addr);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic apb_write(input addr_t addr, input data_t wdata, output logic err);
        data_t unused;
        run_transfer(1'b1, addr, wdata, unused, err);
    endtask

    task automatic apb_read(input addr_t addr, output data_t rdata, output logic err);
        run_transfer(1'b0, addr, '0, rdata, err);
    endtask

    task automatic queue_data(input data_t got, input data_t exp, input string tag);
        got_data_q.push_back(got);
        exp_data_q.push_back(exp);
        data_tag_q.push_back(tag);
    endtask

    task automatic expect_write(input addr_t addr, input data_t wdata, input logic exp_err);
        logic err;
        apb_write(addr, wdata, err);
        queue_data(data_t'(err), data_t'(exp_err), $sformatf("pslverr write %h", addr));
    endtask

    task automatic expect_read(input addr_t addr, input data_t exp, input logic exp_err);
        data_t rd;
        logic  err;
        apb_read(addr, rd, err);
        queue_data(rd, exp, $sformatf("read data %h", addr));
        queue_data(data_t'(err), data_t'(exp_err), $sformatf("pslverr read %h", addr));
    endtask

    task automatic expect_claim(input int t, input src_id_t exp);
        data_t rd;
        logic  err;
        apb_read(plic_addr(12'h204 + 8 * t), rd, err);
        got_id_q.push_back(src_id_t'(rd));
        exp_id_q.push_back(exp);
        id_tag_q.push_back($sformatf("claim target %0d", t));
        queue_data(rd >> $bits(src_id_t), '0, $sformatf("claim upper bits target %0d", t));
        queue_data(data_t'(err), '0, $sformatf("pslverr claim target %0d", t));
    endtask

    task automatic set_prio(input int i, input data_t v);
        expect_write(plic_addr(4 * i), v, 1'b0);
        if (i != 0) begin
            prio_m[i*PW +: PW] = v[PW-1:0];
        end
    endtask

    task automatic set_enable(input int t, input data_t v);
        expect_write(plic_addr(12'h100 + 4 * t), v, 1'b0);
        en_m[t] = v[`PERIPH_NUM_SRC-1:0];
    endtask

    task automatic set_threshold(input int t, input data_t v);
        expect_write(plic_addr(12'h200 + 8 * t), v, 1'b0);
        thr_m[t] = v[PW-1:0];
    endtask

    task automatic wait_eip(input tgt_vec_t mask, input tgt_vec_t val, input string what);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while ((eip & mask) !== val && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if ((eip & mask) !== val) begin
            timeouts++;
            $display("Timed out waiting for %s", what);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic sample_eip(input string tag);
        @(negedge clk);
        check_eip(eip, ref_eip(), tag);
        @(posedge clk);
        #1;
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        data_t    v;
        data_t    cmp;
        src_id_t  id;
        src_id_t  exp_id;
        ext_irq_t mask;
        int       k;
        int       cnt;

        apb_req     = '0;
        irq         = '0;
        prio_m      = '0;
        pend_m      = '0;
        data_errors = 0;
        id_errors   = 0;
        eip_errors  = 0;
        timeouts    = 0;
        for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
            en_m[t]  = '0;
            thr_m[t] = '0;
        end
        v = $urandom(32'he401d2a1);

        cnt = 0;
        while (rst_n !== 1'b1 && cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("Reset was never released");
        end
        @(posedge clk);
        #1;
        sample_eip("eip after reset");

        // Empty regions answer with an error and change nothing
        for (int r = 2; r < 16; r++) begin
            v = $urandom;
            expect_write(addr_t'({4'(r), 12'h004}), v, 1'b1);
            expect_write(addr_t'({4'(r), 12'h100}), v, 1'b1);
            expect_read(addr_t'({4'(r), (12'($urandom) & 12'hFFC)}), `PERIPH_ERR_RDATA, 1'b1);
        end
        expect_read(plic_addr(12'h004), '0, 1'b0);
        expect_read(plic_addr(12'h100), '0, 1'b0);
        expect_read(tmr_addr(12'h004), '0, 1'b0);

        // Register readback
        for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
            set_prio(i, data_t'($urandom));
            expect_read(plic_addr(4 * i), data_t'(prio_m[i*PW +: PW]), 1'b0);
        end
        for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
            set_enable(t, data_t'($urandom));
            expect_read(plic_addr(12'h100 + 4 * t), data_t'(en_m[t]), 1'b0);
            set_threshold(t, data_t'($urandom));
            expect_read(plic_addr(12'h200 + 8 * t), data_t'(thr_m[t]), 1'b0);
        end
        expect_read(plic_addr(12'h080), data_t'(pend_m), 1'b0);
        for (int i = 1; i < `PERIPH_NUM_SRC; i++) begin
            set_prio(i, '0);
        end
        for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
            set_enable(t, '0);
            set_threshold(t, '0);
        end

        // Single level source on target 0 with target 1 masked by threshold
        k  = int'($urandom_range(4, 0));
        id = src_id_t'(k + 3);
        set_threshold(0, data_t'($urandom_range(5, 0)));
        set_prio(int'(id), data_t'(int'(thr_m[0]) + 1
                 + int'($urandom_range(6 - int'(thr_m[0]), 0))));
        set_enable(0, data_t'(src_vec_t'(1) << id));
        set_threshold(1, data_t'(7));
        set_enable(1, data_t'(src_vec_t'(1) << id));
        irq[k]     = 1'b1;
        pend_m[id] = 1'b1;
        wait_eip(2'b01, 2'b01, "eip_o[0] from a level source");
        sample_eip("level source eip");
        expect_claim(0, id);
        pend_m[id] = 1'b0;
        irq[k]     = 1'b0;
        expect_write(plic_addr(12'h204), data_t'(id), 1'b0);
        sample_eip("eip after complete");
        expect_read(plic_addr(12'h080), data_t'(pend_m), 1'b0);

        // Several level sources claimed in priority order
        for (int i = 3; i < `PERIPH_NUM_SRC; i++) begin
            set_prio(i, data_t'($urandom));
        end
        set_threshold(0, data_t'($urandom_range(3, 0)));
        set_threshold(1, data_t'($urandom_range(7, 0)));
        set_enable(0, data_t'(8'hF8));
        set_enable(1, data_t'($urandom));
        mask = ext_irq_t'($urandom) | ext_irq_t'(1 << $urandom_range(4, 0));
        irq  = mask;
        pend_m[`PERIPH_NUM_SRC-1:3] = mask;
        repeat (2) begin
            @(posedge clk);
        end
        #1;
        for (int n = 0; n < `PERIPH_NUM_SRC; n++) begin
            exp_id = ref_claim(pend_m, en_m[0], prio_m, thr_m[0]);
            sample_eip("eip before claim");
            expect_claim(0, exp_id);
            if (exp_id == '0) begin
                break;
            end
            pend_m[exp_id]          = 1'b0;
            irq[int'(exp_id) - 3]   = 1'b0;
            expect_write(plic_addr(12'h204), data_t'(exp_id), 1'b0);
        end
        irq = '0;

        // Timer 0 drives source 1
        set_enable(1, '0);
        set_enable(0, data_t'(8'h02));
        set_threshold(0, '0);
        set_prio(1, data_t'($urandom_range(7, 1)));
        cmp = data_t'(20 + $urandom_range(20, 0));
        expect_write(tmr_addr(12'h008), cmp, 1'b0);
        expect_write(tmr_addr(12'h004), '0, 1'b0);
        expect_write(tmr_addr(12'h000), data_t'(1), 1'b0);
        wait_eip(2'b01, 2'b01, "timer 0 interrupt");
        pend_m[1] = 1'b1;
        sample_eip("timer eip");
        expect_claim(0, ref_claim(pend_m, en_m[0], prio_m, thr_m[0]));
        pend_m[1] = 1'b0;
        expect_write(tmr_addr(12'h000), '0, 1'b0);
        v = $urandom;
        expect_write(tmr_addr(12'h004), v, 1'b0);
        expect_read(tmr_addr(12'h004), v, 1'b0);
        expect_read(tmr_addr(12'h008), cmp, 1'b0);
        expect_read(tmr_addr(12'h004), v, 1'b0);
        expect_write(plic_addr(12'h204), data_t'(1), 1'b0);
        sample_eip("eip after timer complete");

        cnt = 0;
        while ((got_data_q.size() != 0 || got_id_q.size() != 0) && cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        @(negedge clk);
        if (got_data_q.size() != 0 || got_id_q.size() != 0) begin
            timeouts++;
            $display("Read results were left unchecked");
        end

        $display("data errors %0d, id errors %0d, eip errors %0d, timeouts %0d",
                 data_errors, id_errors, eip_errors, timeouts);
        if (data_errors + id_errors + eip_errors + timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/periph_properties.sv ====
/*
 * Peripheral subsystem port checks
 * APB response rules and interrupt outputs during reset
 */
`timescale 1ns/1ps
`default_nettype none

module periph_properties (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input periph_pkg::apb_req_t apb_req_i,
    input periph_pkg::apb_rsp_t apb_rsp_i,
    input periph_pkg::tgt_vec_t eip_i
);
    import periph_pkg::*;

    logic access;

    assign access = apb_req_i.psel & apb_req_i.penable;

    // Slave error only on a completing access
    a_slverr_in_access: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        apb_rsp_i.pslverr |-> (access && apb_rsp_i.pready)
    ) else $error("pslverr seen outside a completing access cycle");

    // Zero-wait slaves
    a_ready_in_access: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        access |-> apb_rsp_i.pready
    ) else $error("access cycle without pready");

    a_eip_low_in_reset: assert property (
        @(posedge clk_i)
        !rst_n_i |-> (eip_i == '0)
    ) else $error("eip_o high while in reset");

endmodule

bind periph_top periph_properties u_properties (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .apb_req_i (apb_req_i),
    .apb_rsp_i (apb_rsp_o),
    .eip_i     (eip_o)
);

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
/*
 * Testbench clock and reset
 * 10 ns clock, active-low reset held for 8 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (8) begin
            @(posedge clk_o);
        end
        #2;
        rst_n_o = 1'b1;
    end

    always #5 clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== src/periph_top.sv ====
/*
 * APB peripheral subsystem
 * Decoder, timers, interrupt gateways and interrupt controller
 */
`timescale 1ns/1ps
`default_nettype none

`include "periph_settings.svh"

module periph_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  periph_pkg::apb_req_t apb_req_i,
    output periph_pkg::apb_rsp_t apb_rsp_o,
    input  periph_pkg::ext_irq_t irq_i,
    output periph_pkg::tgt_vec_t eip_o
);
    import periph_pkg::*;

    localparam src_vec_t EDGE_MASK = `PERIPH_EDGE_MASK;

    apb_req_t                     plic_req;
    apb_req_t                     tmr_req;
    apb_rsp_t                     plic_rsp;
    apb_rsp_t                     tmr_rsp;
    logic [`PERIPH_NUM_TIMER-1:0] tmr_irq;
    logic [`PERIPH_NUM_SRC-1:1]   src_in;
    src_vec_t                     pending;
    src_vec_t                     claim;
    src_vec_t                     complete;

    // Slot 0 is "no interrupt", timers first, then external lines
    assign src_in     = {irq_i, tmr_irq};
    assign pending[0] = 1'b0;

    apb_periph_decoder u_decoder (
        .apb_req_i  (apb_req_i),
        .apb_rsp_o  (apb_rsp_o),
        .plic_req_o (plic_req),
        .tmr_req_o  (tmr_req),
        .plic_rsp_i (plic_rsp),
        .tmr_rsp_i  (tmr_rsp)
    );

    apb_timer u_timer (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .apb_req_i (tmr_req),
        .apb_rsp_o (tmr_rsp),
        .irq_o     (tmr_irq)
    );

    for (genvar i = 1; i < `PERIPH_NUM_SRC; i++) begin : g_gw
        irq_gateway #(
            .EDGE (EDGE_MASK[i])
        ) u_gateway (
            .clk_i      (clk_i),
            .rst_n_i    (rst_n_i),
            .src_i      (src_in[i]),
            .claim_i    (claim[i]),
            .complete_i (complete[i]),
            .pending_o  (pending[i])
        );
    end

    plic_core u_plic (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .apb_req_i  (plic_req),
        .apb_rsp_o  (plic_rsp),
        .pending_i  (pending),
        .claim_o    (claim),
        .complete_o (complete),
        .eip_o      (eip_o)
    );

endmodule

`default_nettype wire

// ==== src/apb_timer.sv ====
/*
 * APB timer block
 * Free-running counters with enable and compare, one-cycle match pulse
 */
`timescale 1ns/1ps
`default_nettype none

`include "periph_settings.svh"

module apb_timer (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  periph_pkg::apb_req_t         apb_req_i,
    output periph_pkg::apb_rsp_t         apb_rsp_o,
    output logic [`PERIPH_NUM_TIMER-1:0] irq_o
);
    import periph_pkg::*;

    logic [11:0] off;
    logic        wr_en;
    data_t       rd_tmr [`PERIPH_NUM_TIMER];
    data_t       rdata;

    assign off   = apb_req_i.paddr[11:0];
    assign wr_en = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

    for (genvar n = 0; n < `PERIPH_NUM_TIMER; n++) begin : g_tmr
        logic  en_q;
        data_t cnt_q;
        data_t cmp_q;
        logic  irq_q;
        logic  hit;
        logic  match;

        // 16-byte slot per timer
        assign hit   = (off[11:4] == 8'(n));
        assign match = en_q && (cnt_q == cmp_q);

        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                en_q  <= 1'b0;
                cnt_q <= '0;
                cmp_q <= '0;
                irq_q <= 1'b0;
            end else begin
                irq_q <= match;
                if (wr_en && hit && (off[3:0] == 4'h0)) begin
                    en_q <= apb_req_i.pwdata[0];
                end
                if (wr_en && hit && (off[3:0] == 4'h8)) begin
                    cmp_q <= apb_req_i.pwdata;
                end
                // Software write wins over counting
                if (wr_en && hit && (off[3:0] == 4'h4)) begin
                    cnt_q <= apb_req_i.pwdata;
                end else if (match) begin
                    cnt_q <= '0;
                end else if (en_q) begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end

        assign rd_tmr[n] = !hit                 ? '0 :
                           (off[3:0] == 4'h0)   ? data_t'(en_q) :
                           (off[3:0] == 4'h4)   ? cnt_q :
                           (off[3:0] == 4'h8)   ? cmp_q : '0;
        assign irq_o[n]  = irq_q;
    end

    always_comb begin
        rdata = '0;
        for (int n = 0; n < `PERIPH_NUM_TIMER; n++) begin
            rdata = rdata | rd_tmr[n];
        end
    end

    assign apb_rsp_o.prdata  = rdata;
    assign apb_rsp_o.pready  = apb_req_i.psel & apb_req_i.penable;
    assign apb_rsp_o.pslverr = 1'b0;

endmodule

`default_nettype wire

// ==== src/plic_core.sv ====
/*
 * Interrupt controller core
 * Priority, enable, threshold and claim/complete registers on APB,
 * with one highest-priority arbiter per target
 */
`timescale 1ns/1ps
`default_nettype none

`include "periph_settings.svh"

module plic_core (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  periph_pkg::apb_req_t apb_req_i,
    output periph_pkg::apb_rsp_t apb_rsp_o,
    input  periph_pkg::src_vec_t pending_i,
    output periph_pkg::src_vec_t claim_o,
    output periph_pkg::src_vec_t complete_o,
    output periph_pkg::tgt_vec_t eip_o
);
    import periph_pkg::*;

    logic [11:0] off;
    logic        rd_en;
    logic        wr_en;
    data_t       rdata;
    src_id_t     cpl_id;

    prio_t       prio_q   [`PERIPH_NUM_SRC];
    src_vec_t    enable_q [`PERIPH_NUM_TGT];
    prio_t       thresh_q [`PERIPH_NUM_TGT];
    src_id_t     winner   [`PERIPH_NUM_TGT];

    assign off    = apb_req_i.paddr[11:0];
    assign rd_en  = apb_req_i.psel & apb_req_i.penable & ~apb_req_i.pwrite;
    assign wr_en  = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;
    assign cpl_id = apb_req_i.pwdata[$bits(src_id_t)-1:0];

    // ------------------------------------------------------------
    // Configuration registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
                prio_q[i] <= '0;
            end
            for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
                enable_q[t] <= '0;
                thresh_q[t] <= '0;
            end
        end else if (wr_en) begin
            // source 0 is hardwired to priority 0
            for (int i = 1; i < `PERIPH_NUM_SRC; i++) begin
                if (off == 12'(4 * i)) begin
                    prio_q[i] <= apb_req_i.pwdata[`PERIPH_PRIO_W-1:0];
                end
            end
            for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
                if (off == 12'(12'h100 + 4 * t)) begin
                    enable_q[t] <= apb_req_i.pwdata[`PERIPH_NUM_SRC-1:0];
                end
                if (off == 12'(12'h200 + 8 * t)) begin
                    thresh_q[t] <= apb_req_i.pwdata[`PERIPH_PRIO_W-1:0];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Per-target arbitration
    // ------------------------------------------------------------
    // Strict greater-than keeps the lowest ID on ties
    always_comb begin
        prio_t best_prio;
        for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
            best_prio = thresh_q[t];
            winner[t] = '0;
            for (int i = 1; i < `PERIPH_NUM_SRC; i++) begin
                if (pending_i[i] && enable_q[t][i] && (prio_q[i] > best_prio)) begin
                    best_prio = prio_q[i];
                    winner[t] = src_id_t'(i);
                end
            end
            eip_o[t] = (winner[t] != '0);
        end
    end

    // Read mux plus claim and complete strobes
    always_comb begin
        rdata      = '0;
        claim_o    = '0;
        complete_o = '0;
        for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
            if (off == 12'(4 * i)) begin
                rdata = data_t'(prio_q[i]);
            end
        end
        if (off == 12'h080) begin
            rdata = data_t'(pending_i);
        end
        for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
            if (off == 12'(12'h100 + 4 * t)) begin
                rdata = data_t'(enable_q[t]);
            end
            if (off == 12'(12'h200 + 8 * t)) begin
                rdata = data_t'(thresh_q[t]);
            end
            if (off == 12'(12'h204 + 8 * t)) begin
                rdata = data_t'(winner[t]);
                if (rd_en && (winner[t] != '0)) begin
                    claim_o[winner[t]] = 1'b1;
                end
                if (wr_en && (cpl_id != '0)) begin
                    complete_o[cpl_id] = 1'b1;
                end
            end
        end
    end

    assign apb_rsp_o.prdata  = rdata;
    assign apb_rsp_o.pready  = apb_req_i.psel & apb_req_i.penable;
    assign apb_rsp_o.pslverr = 1'b0;

endmodule

`default_nettype wire

// ==== src/irq_gateway.sv ====
/*
 * Interrupt gateway
 * Captures a level or edge request into pending, holds off until complete
 */
`timescale 1ns/1ps
`default_nettype none

module irq_gateway #(
    parameter bit EDGE = 1'b0
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic src_i,
    input  logic claim_i,
    input  logic complete_i,
    output logic pending_o
);

    logic src_q;
    logic pending_q;
    logic inflight_q;
    logic req;

    // Edge sources only count the rising transition
    assign req = EDGE ? (src_i & ~src_q) : src_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            src_q      <= 1'b0;
            pending_q  <= 1'b0;
            inflight_q <= 1'b0;
        end else begin
            src_q <= src_i;
            if (claim_i) begin
                pending_q  <= 1'b0;
                inflight_q <= 1'b1;
            end else begin
                if (complete_i) begin
                    inflight_q <= 1'b0;
                end
                // a request in the completing cycle is accepted
                if (req && (!inflight_q || complete_i)) begin
                    pending_q <= 1'b1;
                end
            end
        end
    end

    assign pending_o = pending_q;

endmodule

`default_nettype wire

// ==== src/apb_periph_decoder.sv ====
/*
 * APB region decoder
 * Routes psel to the interrupt controller or the timers by address region
 * and answers every empty region with a slave error
 */
`timescale 1ns/1ps
`default_nettype none

`include "periph_settings.svh"

module apb_periph_decoder (
    input  periph_pkg::apb_req_t apb_req_i,
    output periph_pkg::apb_rsp_t apb_rsp_o,
    output periph_pkg::apb_req_t plic_req_o,
    output periph_pkg::apb_req_t tmr_req_o,
    input  periph_pkg::apb_rsp_t plic_rsp_i,
    input  periph_pkg::apb_rsp_t tmr_rsp_i
);
    import periph_pkg::*;

    logic [3:0] region;
    logic       access;
    apb_rsp_t   err_rsp;

    // Region code sits in the top nibble
    assign region = apb_req_i.paddr[`PERIPH_ADDR_W-1 -: 4];
    assign access = apb_req_i.psel & apb_req_i.penable;

    // Answer for regions with no peripheral behind them
    assign err_rsp.prdata  = `PERIPH_ERR_RDATA;
    assign err_rsp.pready  = access;
    assign err_rsp.pslverr = access;

    always_comb begin
        plic_req_o      = apb_req_i;
        tmr_req_o       = apb_req_i;
        plic_req_o.psel = apb_req_i.psel & (region == `PERIPH_REGION_PLIC);
        tmr_req_o.psel  = apb_req_i.psel & (region == `PERIPH_REGION_TIMER);

        case (region)
            `PERIPH_REGION_PLIC:  apb_rsp_o = plic_rsp_i;
            `PERIPH_REGION_TIMER: apb_rsp_o = tmr_rsp_i;
            default:              apb_rsp_o = err_rsp;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/periph_pkg.sv ====
/*
 * Peripheral subsystem types
 * Vector typedefs and the APB request and response structs
 */
`default_nettype none

`include "periph_settings.svh"

package periph_pkg;

    typedef logic [`PERIPH_ADDR_W-1:0]          addr_t;
    typedef logic [`PERIPH_DATA_W-1:0]          data_t;
    typedef logic [`PERIPH_PRIO_W-1:0]          prio_t;
    typedef logic [$clog2(`PERIPH_NUM_SRC)-1:0] src_id_t;
    typedef logic [`PERIPH_NUM_SRC-1:0]         src_vec_t;
    typedef logic [`PERIPH_NUM_TGT-1:0]         tgt_vec_t;
    typedef logic [`PERIPH_NUM_EXT-1:0]         ext_irq_t;

    // APB3 master side
    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        data_t pwdata;
    } apb_req_t;

    // APB3 slave side
    typedef struct packed {
        data_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// ==== src/periph_settings.svh ====
/*
 * Peripheral subsystem settings
 * Bus widths, interrupt source and target counts, region map and edge mask
 */
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

`define PERIPH_ADDR_W        16
`define PERIPH_DATA_W        32
`define PERIPH_NUM_SRC       8
`define PERIPH_NUM_EXT       5
`define PERIPH_NUM_TGT       2
`define PERIPH_PRIO_W        3
`define PERIPH_NUM_TIMER     2

// Timer sources 1 and 2 are edge triggered
`define PERIPH_EDGE_MASK     8'b0000_0110

`define PERIPH_REGION_PLIC   4'h0
`define PERIPH_REGION_TIMER  4'h1
`define PERIPH_ERR_RDATA     32'hDEADBEEF

`endif
